// ==== Makefile ====
# Verilator build, run, lint and clean for the transmit guard

TB  := tb_afu_tx_guard
LOG := sim.log

.PHONY: all run lint clean

all: run

obj_dir/V$(TB): afu_tx_guard.f hw/*.sv hw/*.svh dv/*.sv
	verilator --binary --timing --assert -Wno-fatal -f afu_tx_guard.f \
		--top-module $(TB) -Mdir obj_dir -o V$(TB)

run: obj_dir/V$(TB)
	./obj_dir/V$(TB) 2>&1 | tee $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG); then exit 1; fi
	@grep -q "TEST RESULT: PASS" $(LOG)

lint:
	verilator --lint-only -Wall --timing -f afu_tx_guard.f --top-module afu_tx_guard

clean:
	rm -rf obj_dir $(LOG)

// ==== afu_tx_guard.f ====
+incdir+hw
hw/prot_chk_pkg.sv
hw/tlp_hdr_decoder.sv
hw/tlp_rule_checker.sv
hw/tx_traffic_gate.sv
hw/prot_chk_csr.sv
hw/afu_tx_guard.sv
dv/tb_afu_tx_guard.sv

// ==== dv/tb_afu_tx_guard.sv ====
// Testbench for the accelerator transmit guard
// Stimulus table, scoreboard, APB tasks and result reporting
`timescale 1ns/1ps
`include "prot_chk_consts.svh"

module tb_afu_tx_guard;

   localparam int N_TLP = 16;

   logic                  clk = 1'b0;
   logic                  rst_n;
   logic                  i_tx_valid;
   logic                  o_tx_ready;
   logic [`PC_DATA_W-1:0] i_tx_data;
   logic                  i_tx_last;
   logic                  i_tx_pu_mode;
   logic                  o_host_valid;
   logic                  i_host_ready = 1'b0;
   logic [`PC_DATA_W-1:0] o_host_data;
   logic                  o_host_last;
   logic                  i_psel;
   logic                  i_penable;
   logic                  i_pwrite;
   logic [`PC_APB_AW-1:0] i_paddr;
   logic [31:0]           i_pwdata;
   logic [31:0]           o_prdata;

   // Stimulus table, one row per TLP
   logic        t_mode  [N_TLP];   // 1 selects the PU layout
   logic [7:0]  t_fmt   [N_TLP];
   logic [23:0] t_len   [N_TLP];   // Raw length field, DW in PU mode
   logic [9:0]  t_tag   [N_TLP];
   int          t_beats [N_TLP];   // Header beat included
   logic [3:0]  t_err   [N_TLP];   // {malformed, max_payload, max_rd_req, max_tag}
   logic        t_chk   [N_TLP];   // Read registers and clear after this row

   logic [64:0] exp_q[$];          // {last, data}
   integer      seed = 32'hc958_50d0;
   int          errors;
   int          beats_seen;
   int          cycles;
   int          cycle_limit;
   int          total_beats;
   int          n_rows;
   int          beat_cnt;
   logic        blocked;           // Model of the blocking state
   logic [3:0]  err_acc;           // Errors seen since the last clear
   logic [63:0] first_hdr;

   afu_tx_guard u_afu_tx_guard (
      .clk          (clk),
      .rst_n        (rst_n),
      .i_tx_valid   (i_tx_valid),
      .o_tx_ready   (o_tx_ready),
      .i_tx_data    (i_tx_data),
      .i_tx_last    (i_tx_last),
      .i_tx_pu_mode (i_tx_pu_mode),
      .o_host_valid (o_host_valid),
      .i_host_ready (i_host_ready),
      .o_host_data  (o_host_data),
      .o_host_last  (o_host_last),
      .i_psel       (i_psel),
      .i_penable    (i_penable),
      .i_pwrite     (i_pwrite),
      .i_paddr      (i_paddr),
      .i_pwdata     (i_pwdata),
      .o_prdata     (o_prdata)
   );

   always #50 clk = ~clk;

   // Host back-pressure, ready about three cycles in four
   always @(negedge clk) i_host_ready <= (($random(seed) & 3) != 0);

   always @(posedge clk) begin
      cycles++;
      if (cycles >= cycle_limit) begin
         $display("Timeout after %0d cycles, the run did not finish", cycles);
         $display("TEST RESULT: FAIL");
         $finish;
      end
   end

   task automatic check_value(input string name, input logic [63:0] got,
                              input logic [63:0] exp);
      if (got !== exp) begin
         $display("Mismatch %s: got %h, expected %h", name, got, exp);
         errors++;
      end
   endtask

   // ########################################
   // Scoreboard on the host stream
   // ########################################
   always @(negedge clk) begin
      logic [64:0] exp_beat;
      #1;
      if (rst_n && o_host_valid && i_host_ready) begin
         beats_seen++;
         if (exp_q.size() == 0) begin
            $display("Beat %h reached the host although no clean beat was pending",
                     o_host_data);
            errors++;
         end else begin
            exp_beat = exp_q.pop_front();
            check_value("o_host_data", o_host_data, exp_beat[63:0]);
            check_value("o_host_last", 64'(o_host_last), 64'(exp_beat[64]));
         end
      end
   end

   task automatic add_row(input logic mode, input logic [7:0] fmt, input logic [23:0] len,
                          input logic [9:0] tag, input int beats, input logic [3:0] err,
                          input logic chk);
      t_mode[n_rows]  = mode;
      t_fmt[n_rows]   = fmt;
      t_len[n_rows]   = len;
      t_tag[n_rows]   = tag;
      t_beats[n_rows] = beats;
      t_err[n_rows]   = err;
      t_chk[n_rows]   = chk;
      n_rows++;
   endtask

   task automatic load_table();
      //      mode  fmt            len       tag      beats err      chk
      add_row(1'b1, `PC_FMT_M_WR,  24'd16,   10'd5,   3, 4'b0000, 1'b0);  // 64 B
      add_row(1'b0, `PC_FMT_DM_WR, 24'd512,  10'd7,   4, 4'b0000, 1'b0);  // At payload limit
      add_row(1'b1, `PC_FMT_M_RD,  24'd128,  10'd95,  1, 4'b0000, 1'b0);  // 512 B, top tag
      add_row(1'b0, `PC_FMT_DM_RD, 24'd256,  10'd0,   1, 4'b0000, 1'b0);
      add_row(1'b0, `PC_FMT_CPLD,  24'd1024, 10'd200, 2, 4'b0000, 1'b0);  // Limits skip completions
      add_row(1'b1, `PC_FMT_M_WR,  24'd0,    10'd1,   2, 4'b0100, 1'b1);  // 0 DW is 4096 B
      add_row(1'b0, `PC_FMT_M_WR,  24'd8,    10'd2,   2, 4'b1000, 1'b1);  // PU code in DM mode
      add_row(1'b0, `PC_FMT_DM_RD, 24'd516,  10'd3,   1, 4'b0010, 1'b1);
      add_row(1'b1, `PC_FMT_M_RD,  24'd4,    10'd96,  1, 4'b0001, 1'b1);
      add_row(1'b0, 8'hff,         24'd16,   10'd4,   2, 4'b1000, 1'b0);  // First error
      add_row(1'b0, `PC_FMT_DM_WR, 24'd1024, 10'd5,   3, 4'b0100, 1'b0);  // Second error
      add_row(1'b1, `PC_FMT_M_WR,  24'd8,    10'd6,   2, 4'b0000, 1'b0);  // Eaten while blocked
      add_row(1'b0, `PC_FMT_DM_RD, 24'd64,   10'd7,   1, 4'b0000, 1'b1);
      add_row(1'b1, `PC_FMT_M_WR,  24'd8,    10'd8,   4, 4'b0000, 1'b0);
      add_row(1'b0, `PC_FMT_DM_WR, 24'd500,  10'd9,   3, 4'b0000, 1'b0);
      add_row(1'b1, `PC_FMT_CPLD,  24'd2,    10'd10,  2, 4'b0000, 1'b0);
   endtask

   // Format in 63:56, row index in the low reserved bits
   function automatic logic [63:0] make_hdr(input int row);
      logic [63:0] h;
      if (t_mode[row]) h = {t_fmt[row], 14'd0, t_len[row][9:0], t_tag[row], 12'd0, 10'(row)};
      else h = {t_fmt[row], t_len[row], t_tag[row], 12'd0, 10'(row)};
      return h;
   endfunction

   // ########################################
   // Stream and APB drivers
   // ########################################
   task automatic send_beat(input logic [63:0] data, input logic last);
      logic done;
      done       = 1'b0;
      i_tx_valid = 1'b1;
      i_tx_data  = data;
      i_tx_last  = last;
      while (!done) begin
         #1;
         done = o_tx_ready;   // Beat moves on the next rising edge
         @(negedge clk);
      end
   endtask

   task automatic send_tlp(input int row);
      logic [63:0] hdr;
      logic [63:0] data;
      logic        push;
      hdr          = make_hdr(row);
      i_tx_pu_mode = t_mode[row];
      push         = !blocked && (t_err[row] == 4'd0);
      if (t_err[row] != 4'd0) begin
         if (err_acc == 4'd0) first_hdr = hdr;
         err_acc = err_acc | t_err[row];
         blocked = 1'b1;
      end
      for (int b = 0; b < t_beats[row]; b++) begin
         data = (b == 0) ? hdr : {8'hd0, 8'(row), 16'h0, 32'(beat_cnt)};
         if (b != 0) beat_cnt++;
         if (push) exp_q.push_back({(b == t_beats[row] - 1), data});
         send_beat(data, b == t_beats[row] - 1);
      end
   endtask

   task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
      i_psel   = 1'b1;
      i_pwrite = 1'b1;
      i_paddr  = addr;
      i_pwdata = data;
      @(negedge clk);
      i_penable = 1'b1;
      @(negedge clk);
      i_psel    = 1'b0;
      i_penable = 1'b0;
      i_pwrite  = 1'b0;
   endtask

   task automatic apb_read(input logic [7:0] addr, output logic [31:0] data);
      i_psel   = 1'b1;
      i_pwrite = 1'b0;
      i_paddr  = addr;
      @(negedge clk);
      i_penable = 1'b1;
      #1;
      data = o_prdata;
      @(negedge clk);
      i_psel    = 1'b0;
      i_penable = 1'b0;
   endtask

   task automatic wait_drain();
      while (exp_q.size() != 0 || o_host_valid) @(negedge clk);
      @(negedge clk);
   endtask

   task automatic check_and_clear();
      logic [31:0] rd;
      wait_drain();
      apb_read(`PC_REG_STATUS, rd);
      check_value("STATUS", 64'(rd), {32'd0, 1'b1, 27'd0, err_acc});
      apb_read(`PC_REG_HDR_LO, rd);
      check_value("HDR_LO", 64'(rd), {32'd0, first_hdr[31:0]});
      apb_read(`PC_REG_HDR_HI, rd);
      check_value("HDR_HI", 64'(rd), {32'd0, first_hdr[63:32]});
      apb_write(`PC_REG_CLEAR, 32'h1);
      apb_read(`PC_REG_STATUS, rd);
      check_value("STATUS", 64'(rd), 64'd0);   // Blocking gone too
      err_acc = 4'd0;
      blocked = 1'b0;
   endtask

   initial begin
      logic [31:0] rd;
      rst_n        = 1'b0;
      i_tx_valid   = 1'b0;
      i_tx_data    = '0;
      i_tx_last    = 1'b0;
      i_tx_pu_mode = 1'b0;
      i_psel       = 1'b0;
      i_penable    = 1'b0;
      i_pwrite     = 1'b0;
      i_paddr      = '0;
      i_pwdata     = '0;
      errors       = 0;
      beats_seen   = 0;
      beat_cnt     = 0;
      blocked      = 1'b0;
      err_acc      = 4'd0;
      first_hdr    = '0;
      n_rows       = 0;
      total_beats  = 0;
      load_table();
      for (int r = 0; r < n_rows; r++) total_beats += t_beats[r];
      cycle_limit = total_beats * 4 + 200;
      repeat (10) @(negedge clk);
      rst_n = 1'b1;
      @(negedge clk);
      // Idle state out of reset
      check_value("o_tx_ready", 64'(o_tx_ready), 64'd1);
      check_value("o_host_valid", 64'(o_host_valid), 64'd0);
      apb_read(`PC_REG_STATUS, rd);
      check_value("STATUS", 64'(rd), 64'd0);
      for (int r = 0; r < n_rows; r++) begin
         send_tlp(r);
         if (t_chk[r]) begin
            i_tx_valid = 1'b0;
            i_tx_last  = 1'b0;
            check_and_clear();
         end
      end
      i_tx_valid = 1'b0;
      wait_drain();
      $display("Run complete: %0d host beats checked, %0d errors", beats_seen, errors);
      if (errors == 0) begin
         $display("TEST RESULT: PASS");
      end else begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

endmodule

// ==== hw/afu_tx_guard.sv ====
// Top level of the accelerator transmit guard
// Decoder, rule checker, traffic gate and APB registers
`timescale 1ns/1ps
`include "prot_chk_consts.svh"

module afu_tx_guard (
   input  logic                  clk,
   input  logic                  rst_n,
   // Accelerator stream
   input  logic                  i_tx_valid,
   output logic                  o_tx_ready,
   input  logic [`PC_DATA_W-1:0] i_tx_data,
   input  logic                  i_tx_last,
   input  logic                  i_tx_pu_mode,
   // Host stream
   output logic                  o_host_valid,
   input  logic                  i_host_ready,
   output logic [`PC_DATA_W-1:0] o_host_data,
   output logic                  o_host_last,
   // APB
   input  logic                  i_psel,
   input  logic                  i_penable,
   input  logic                  i_pwrite,
   input  logic [`PC_APB_AW-1:0] i_paddr,
   input  logic [31:0]           i_pwdata,
   output logic [31:0]           o_prdata
);

   import prot_chk_pkg::*;

   logic                  hdr_strobe;
   t_tlp_hdr              hdr;
   logic [`PC_LEN_W-1:0]  len_bytes;
   logic [`PC_TAG_W-1:0]  tag;
   logic                  is_wr;
   logic                  is_rd;
   logic                  fmt_known;
   t_err_vec              err_vec;
   logic [`PC_DATA_W-1:0] err_hdr;
   logic                  blocking;
   logic                  clear;

   tlp_hdr_decoder u_decoder (
      .clk          (clk),
      .rst_n        (rst_n),
      .i_tx_valid   (i_tx_valid),
      .i_tx_ready   (o_tx_ready),
      .i_tx_last    (i_tx_last),
      .i_tx_pu_mode (i_tx_pu_mode),
      .i_tx_data    (i_tx_data),
      .o_hdr_strobe (hdr_strobe),
      .o_hdr        (hdr),
      .o_len_bytes  (len_bytes),
      .o_tag        (tag),
      .o_is_wr      (is_wr),
      .o_is_rd      (is_rd),
      .o_fmt_known  (fmt_known)
   );

   tlp_rule_checker u_checker (
      .clk          (clk),
      .rst_n        (rst_n),
      .i_hdr_strobe (hdr_strobe),
      .i_hdr        (hdr),
      .i_len_bytes  (len_bytes),
      .i_tag        (tag),
      .i_is_wr      (is_wr),
      .i_is_rd      (is_rd),
      .i_fmt_known  (fmt_known),
      .o_err_vec    (err_vec),
      .o_err_hdr    (err_hdr)
   );

   tx_traffic_gate u_gate (
      .clk          (clk),
      .rst_n        (rst_n),
      .i_tx_valid   (i_tx_valid),
      .o_tx_ready   (o_tx_ready),
      .i_tx_data    (i_tx_data),
      .i_tx_last    (i_tx_last),
      .i_err_vec    (err_vec),
      .i_clear      (clear),
      .o_blocking   (blocking),
      .o_host_valid (o_host_valid),
      .i_host_ready (i_host_ready),
      .o_host_data  (o_host_data),
      .o_host_last  (o_host_last)
   );

   prot_chk_csr u_csr (
      .clk          (clk),
      .rst_n        (rst_n),
      .i_psel       (i_psel),
      .i_penable    (i_penable),
      .i_pwrite     (i_pwrite),
      .i_paddr      (i_paddr),
      .i_pwdata     (i_pwdata),
      .o_prdata     (o_prdata),
      .i_err_vec    (err_vec),
      .i_err_hdr    (err_hdr),
      .i_blocking   (blocking),
      .o_clear      (clear)
   );

endmodule

// ==== hw/prot_chk_consts.svh ====
// Constants for the transmit protocol guard
// Widths, format/type codes, protocol limits and register offsets
`ifndef PROT_CHK_CONSTS_SVH
`define PROT_CHK_CONSTS_SVH

// Datapath and field widths
`define PC_DATA_W            64
`define PC_LEN_W             24   // Byte length
`define PC_TAG_W             10
`define PC_PU_LEN_W          10   // PU length field, in dwords
`define PC_PU_ZERO_LEN_BYTES 4096 // PU length of zero means 1024 DW

// Format/type codes
`define PC_FMT_DM_WR 8'h60
`define PC_FMT_DM_RD 8'h20
`define PC_FMT_M_WR  8'h40 // PU only
`define PC_FMT_M_RD  8'h00 // PU only
`define PC_FMT_CPLD  8'h4a

// Protocol limits
`define PC_MAX_PLD_BYTES    512
`define PC_MAX_RD_REQ_BYTES 512
`define PC_MAX_TAGS         96

// APB register map
`define PC_APB_AW     8
`define PC_REG_STATUS 8'h00
`define PC_REG_CLEAR  8'h04
`define PC_REG_HDR_LO 8'h08
`define PC_REG_HDR_HI 8'h0c

`endif

// ==== hw/prot_chk_csr.sv ====
// APB register block for the transmit guard
// Sticky error status, first-error header capture and clear pulse
`timescale 1ns/1ps
`include "prot_chk_consts.svh"

module prot_chk_csr (
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic                   i_psel,
   input  logic                   i_penable,
   input  logic                   i_pwrite,
   input  logic [`PC_APB_AW-1:0]  i_paddr,
   input  logic [31:0]            i_pwdata,
   output logic [31:0]            o_prdata,
   input  prot_chk_pkg::t_err_vec i_err_vec,
   input  logic [`PC_DATA_W-1:0]  i_err_hdr,
   input  logic                   i_blocking,
   output logic                   o_clear
);

   import prot_chk_pkg::*;

   t_err_vec              err_sticky;
   logic [`PC_DATA_W-1:0] err_hdr;
   logic                  wr_acc;
   logic                  rd_acc;
   logic                  clear_wr;

   // Access phase only, no wait states
   assign wr_acc   = i_psel & i_penable & i_pwrite;
   assign rd_acc   = i_psel & i_penable & ~i_pwrite;
   assign clear_wr = wr_acc & (i_paddr == `PC_REG_CLEAR);  // Data value is ignored

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         err_sticky <= '0;
         err_hdr    <= '0;
         o_clear    <= 1'b0;
      end else begin
         o_clear <= clear_wr;
         if (clear_wr) begin
            err_sticky <= '0;
            err_hdr    <= '0;
         end else begin
            err_sticky <= err_sticky | i_err_vec;
            // Only the first error header is kept
            if ((err_sticky == '0) && (|i_err_vec)) err_hdr <= i_err_hdr;
         end
      end
   end

   // ########################################
   // Read mux
   // ########################################
   always_comb begin
      o_prdata = '0;
      if (rd_acc) begin
         case (i_paddr)
            `PC_REG_STATUS: o_prdata = {i_blocking, 27'd0, err_sticky};
            `PC_REG_HDR_LO: o_prdata = err_hdr[31:0];
            `PC_REG_HDR_HI: o_prdata = err_hdr[63:32];
            default:        o_prdata = '0;   // CLEAR reads as zero
         endcase
      end
   end

   a_clear_pulse : assert property (@(posedge clk) disable iff (!rst_n)
      $rose(o_clear) |=> !o_clear);

endmodule

// ==== hw/prot_chk_pkg.sv ====
// Header layouts and error vector type for the transmit guard
// One 64-bit header word, read as PU or DM layout
`include "prot_chk_consts.svh"

package prot_chk_pkg;

   // PU request header, length counted in dwords
   typedef struct packed {
      logic [7:0]              fmt_type;  // 63:56
      logic [13:0]             rsvd_hi;
      logic [`PC_PU_LEN_W-1:0] length;    // 41:32
      logic [`PC_TAG_W-1:0]    tag;       // 31:22
      logic [21:0]             rsvd_lo;
   } t_pu_hdr;

   // DM request header, length counted in bytes
   typedef struct packed {
      logic [7:0]           fmt_type;     // 63:56
      logic [`PC_LEN_W-1:0] length;       // 55:32
      logic [`PC_TAG_W-1:0] tag;          // 31:22
      logic [21:0]          rsvd;
   } t_dm_hdr;

   // Same header beat, decoded per sideband mode bit
   typedef union packed {
      t_pu_hdr pu;
      t_dm_hdr dm;
   } t_tlp_hdr;

   typedef struct packed {
      logic malformed;
      logic max_payload;
      logic max_rd_req;
      logic max_tag;                      // Bit 0
   } t_err_vec;

endpackage

// ==== hw/tlp_hdr_decoder.sv ====
// TLP frame tracking and header decode
// Maps PU or DM header layout onto common fields
`timescale 1ns/1ps
`include "prot_chk_consts.svh"

module tlp_hdr_decoder (
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic                   i_tx_valid,
   input  logic                   i_tx_ready,
   input  logic                   i_tx_last,
   input  logic                   i_tx_pu_mode,
   input  logic [`PC_DATA_W-1:0]  i_tx_data,
   output logic                   o_hdr_strobe,
   output prot_chk_pkg::t_tlp_hdr o_hdr,
   output logic [`PC_LEN_W-1:0]   o_len_bytes,
   output logic [`PC_TAG_W-1:0]   o_tag,
   output logic                   o_is_wr,
   output logic                   o_is_rd,
   output logic                   o_fmt_known
);

   localparam logic [`PC_LEN_W-1:0] PU_ZERO_LEN = `PC_PU_ZERO_LEN_BYTES;

   logic       tx_xfer;
   logic       in_tlp;   // Header already seen, waiting for last
   logic [7:0] fmt;

   assign tx_xfer      = i_tx_valid & i_tx_ready;
   assign o_hdr_strobe = tx_xfer & ~in_tlp;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         in_tlp <= 1'b0;
      end else if (tx_xfer) begin
         in_tlp <= ~i_tx_last;
      end
   end

   assign o_hdr = i_tx_data;
   assign fmt   = o_hdr.pu.fmt_type;       // Same position in both layouts
   assign o_tag = o_hdr.pu.tag;            // Tag sits at 31:22 in both layouts

   always_comb begin
      if (i_tx_pu_mode) begin
         // Dwords to bytes
         if (o_hdr.pu.length == '0) o_len_bytes = PU_ZERO_LEN;
         else o_len_bytes = {{(`PC_LEN_W-`PC_PU_LEN_W-2){1'b0}}, o_hdr.pu.length, 2'b00};
      end else begin
         o_len_bytes = o_hdr.dm.length;
      end
   end

   // M_WR and M_RD only legal in PU mode
   assign o_is_wr     = (fmt == `PC_FMT_DM_WR) | (i_tx_pu_mode & (fmt == `PC_FMT_M_WR));
   assign o_is_rd     = (fmt == `PC_FMT_DM_RD) | (i_tx_pu_mode & (fmt == `PC_FMT_M_RD));
   assign o_fmt_known = o_is_wr | o_is_rd | (fmt == `PC_FMT_CPLD);

   // Stalled beat is held by the accelerator until it transfers
   a_tx_hold : assert property (@(posedge clk) disable iff (!rst_n)
      i_tx_valid && !i_tx_ready |=> i_tx_valid && $stable(i_tx_data) && $stable(i_tx_last));

endmodule

// ==== hw/tlp_rule_checker.sv ====
// Header rule checks
// Malformed, max payload, max read request and tag range, registered
`timescale 1ns/1ps
`include "prot_chk_consts.svh"

module tlp_rule_checker (
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic                   i_hdr_strobe,
   input  prot_chk_pkg::t_tlp_hdr i_hdr,
   input  logic [`PC_LEN_W-1:0]   i_len_bytes,
   input  logic [`PC_TAG_W-1:0]   i_tag,
   input  logic                   i_is_wr,
   input  logic                   i_is_rd,
   input  logic                   i_fmt_known,
   output prot_chk_pkg::t_err_vec o_err_vec,
   output logic [`PC_DATA_W-1:0]  o_err_hdr
);

   logic pld_too_big;
   logic rd_too_big;
   logic tag_bad;

   assign pld_too_big = i_is_wr & (i_len_bytes > `PC_MAX_PLD_BYTES);
   assign rd_too_big  = i_is_rd & (i_len_bytes > `PC_MAX_RD_REQ_BYTES);
   assign tag_bad     = i_is_rd & (i_tag >= `PC_MAX_TAGS);  // Tags only matter on reads

   // Vector is high for one cycle only, lined up with gate stage 1
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         o_err_vec <= '0;
      end else begin
         o_err_vec <= '0;
         if (i_hdr_strobe) begin
            o_err_vec.malformed   <= ~i_fmt_known;
            o_err_vec.max_payload <= pld_too_big;
            o_err_vec.max_rd_req  <= rd_too_big;
            o_err_vec.max_tag     <= tag_bad;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (i_hdr_strobe) o_err_hdr <= i_hdr;
   end

endmodule

// ==== hw/tx_traffic_gate.sv ====
// Two-stage transmit pipeline
// Drops errored TLPs and blocks all traffic until cleared
`timescale 1ns/1ps
`include "prot_chk_consts.svh"

module tx_traffic_gate (
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic                   i_tx_valid,
   output logic                   o_tx_ready,
   input  logic [`PC_DATA_W-1:0]  i_tx_data,
   input  logic                   i_tx_last,
   input  prot_chk_pkg::t_err_vec i_err_vec,
   input  logic                   i_clear,
   output logic                   o_blocking,
   output logic                   o_host_valid,
   input  logic                   i_host_ready,
   output logic [`PC_DATA_W-1:0]  o_host_data,
   output logic                   o_host_last
);

   logic                  s0_valid;
   logic [`PC_DATA_W-1:0] s0_data;
   logic                  s0_last;
   logic                  s0_drop;   // Errored header sits in stage 0
   logic                  s0_adv;
   logic                  s0_load;
   logic                  s1_free;
   logic                  tx_xfer;
   logic                  in_tlp;    // Input side is mid-TLP
   logic                  clr_pend;
   logic                  at_boundary;
   logic                  release_blk;

   // ########################################
   // Handshake and stage control
   // ########################################
   assign s1_free    = ~o_host_valid | i_host_ready;
   assign s0_drop    = s0_valid & (|i_err_vec);
   assign s0_adv     = s0_valid & ~s0_drop & s1_free;
   assign o_tx_ready = o_blocking | ~s0_valid | s0_drop | s1_free;
   assign tx_xfer    = i_tx_valid & o_tx_ready;

   // While blocking, or when the header ahead is dropped, beats are eaten
   assign s0_load = tx_xfer & ~o_blocking & ~s0_drop;

   // Release only between TLPs, so no partial TLP leaks out
   assign at_boundary = tx_xfer ? i_tx_last : ~in_tlp;
   assign release_blk = o_blocking & (i_clear | clr_pend) & at_boundary;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         s0_valid     <= 1'b0;
         o_host_valid <= 1'b0;
         in_tlp       <= 1'b0;
         o_blocking   <= 1'b0;
         clr_pend     <= 1'b0;
      end else begin
         if (s0_load) s0_valid <= 1'b1;
         else if (s0_adv | s0_drop) s0_valid <= 1'b0;

         if (s0_adv) o_host_valid <= 1'b1;
         else if (i_host_ready) o_host_valid <= 1'b0;

         if (tx_xfer) in_tlp <= ~i_tx_last;

         if (s0_drop) o_blocking <= 1'b1;
         else if (release_blk) o_blocking <= 1'b0;

         // Clear that arrives mid-TLP waits for the last beat
         if (~o_blocking | release_blk) clr_pend <= 1'b0;
         else if (i_clear) clr_pend <= 1'b1;
      end
   end

   // ########################################
   // Datapath
   // ########################################
   always_ff @(posedge clk) begin
      if (s0_load) begin
         s0_data <= i_tx_data;
         s0_last <= i_tx_last;
      end
      if (s0_adv) begin
         o_host_data <= s0_data;
         o_host_last <= s0_last;
      end
   end

   a_host_hold : assert property (@(posedge clk) disable iff (!rst_n)
      o_host_valid && !i_host_ready |=> o_host_valid && $stable(o_host_data));

endmodule
